/* all.f */
+incdir+include
design/decode_pkg.sv
design/inst_capture.sv
design/opcode_decode.sv
design/control_flow_unit.sv
design/resp_stage.sv
design/decoder_top.sv
sim/decoder_tb.sv

/* Makefile */
# verilator flow for the decoder testbench

TOP := decoder_tb
OBJ := obj_dir

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir $(OBJ)
	@out=$$(./$(OBJ)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

clean:
	rm -rf $(OBJ)

/* include/decode_ref.svh */
// reference decode model
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

function automatic decode_pkg::decoder_resp_t decode_ref(
    input decode_pkg::virt_t             vaddr,
    input logic [decode_pkg::word_w-1:0] inst
);
    decode_pkg::decoder_resp_t r;
    logic [5:0]                opc;
    logic [5:0]                fn;
    decode_pkg::reg_addr_t     rs;
    decode_pkg::reg_addr_t     rt;
    decode_pkg::virt_t         pc4;
    logic                      br;
    logic                      jmp;
    logic                      call;
    logic                      ret;

    opc = inst[31:26];
    fn  = inst[5:0];
    rs  = inst[25:21];
    rt  = inst[20:16];
    pc4 = vaddr + 32'd4;
    r   = '0;
    r.dec.op         = decode_pkg::OP_SLL;
    r.dec.imm_signed = 1'b1;

    if (opc == decode_pkg::opc_special) begin
        r.dec.rs1 = rs;
        r.dec.rs2 = rt;
        r.dec.rd  = inst[15:11];
        r.dec.is_multicyc = fn inside {[6'o30:6'o33], decode_pkg::fn_mthi, decode_pkg::fn_mtlo};
        case (fn)
            6'o00:   r.dec.op = decode_pkg::OP_SLL;
            6'o02:   r.dec.op = decode_pkg::OP_SRL;
            6'o03:   r.dec.op = decode_pkg::OP_SRA;
            6'o04:   r.dec.op = decode_pkg::OP_SLLV;
            6'o06:   r.dec.op = decode_pkg::OP_SRLV;
            6'o07:   r.dec.op = decode_pkg::OP_SRAV;
            6'o10, 6'o11: r.dec.op = decode_pkg::OP_JALR;
            6'o14:   r.dec.op = decode_pkg::OP_SYSCALL;
            6'o15:   r.dec.op = decode_pkg::OP_BREAK;
            6'o52:   r.dec.op = decode_pkg::OP_SLT;
            6'o53:   r.dec.op = decode_pkg::OP_SLTU;
            default: begin
                if (fn inside {[6'o20:6'o23], [6'o30:6'o33], [6'o40:6'o47]})
                    r.dec.op = decode_pkg::op_t'(
                        (fn[5] ? 17 + fn[2:0] : (fn[3] ? 13 : 9) + fn[1:0]));
                else
                    r.dec.op = decode_pkg::OP_INVALID;
            end
        endcase
    end else if (opc == decode_pkg::opc_regimm) begin
        r.dec.rs1     = rs;
        r.dec.use_imm = 1'b1;
        r.dec.rd      = (rt[4:1] == 4'b1000) ? decode_pkg::link_reg : '0;
        r.dec.op      = (rt[3:1] == 3'b000) ?
                        decode_pkg::op_t'(28 + {rt[4], rt[0]}) : decode_pkg::OP_INVALID;
    end else if (opc[5:2] == 4'b0001) begin
        r.dec.rs1 = rs;
        r.dec.rs2 = rt;
        r.dec.op  = decode_pkg::op_t'(32 + opc[1:0]);
    end else if (opc[5:3] == 3'b001) begin
        r.dec.rs1        = rs;
        r.dec.rd         = rt;
        r.dec.use_imm    = 1'b1;
        r.dec.imm_signed = ~opc[2];
        r.dec.op = opc[2] ? decode_pkg::op_t'(opc[1:0] == 2'b11 ? 27 : 21 + opc[1:0])
                          : decode_pkg::op_t'(opc[1] ? 25 + opc[0] : 17 + opc[0]);
    end else if (opc[5:4] == 2'b10) begin
        r.dec.rs1      = rs;
        r.dec.rs2      = (opc[3] || opc[1:0] == 2'b10) ? rt : '0;
        r.dec.rd       = opc[3] ? '0 : rt;
        r.dec.is_load  = ~opc[3];
        r.dec.is_store = opc[3];
        if (opc[1:0] == 2'b10 || opc[2:0] == 3'b111 || (opc[3] && opc[2])) begin
            r.dec.op = decode_pkg::OP_INVALID;
        end else begin
            r.dec.be = (opc[1:0] == 2'b00) ? 4'b0001 : (opc[1:0] == 2'b01) ? 4'b0011 : 4'b1111;
            r.dec.op = opc[3] ? decode_pkg::op_t'(41 + opc[1] + opc[0])
                              : decode_pkg::op_t'(opc[2] ? 39 + opc[0] : 36 + opc[1] + opc[0]);
        end
    end else if (opc[5:1] == 5'b00001) begin
        r.dec.op = decode_pkg::OP_JAL;
        r.dec.rd = opc[0] ? decode_pkg::link_reg : '0;
    end else if (opc == decode_pkg::opc_cop0 && rs == decode_pkg::cop0_mf) begin
        r.dec.op = decode_pkg::OP_MFC0;
        r.dec.rd = rt;
    end else if (opc == decode_pkg::opc_cop0 && rs == decode_pkg::cop0_mt) begin
        r.dec.op  = decode_pkg::OP_MTC0;
        r.dec.rs1 = rt;
    end else if (opc == decode_pkg::opc_cop0 && rs == decode_pkg::cop0_co
                 && fn == decode_pkg::fn_eret) begin
        r.dec.op = decode_pkg::OP_ERET;
    end else begin
        r.dec.op = decode_pkg::OP_INVALID;
    end

    br   = (opc[5:2] == 4'b0001) || (opc == decode_pkg::opc_regimm && rt[3:1] == 3'b000);
    jmp  = (opc[5:1] == 5'b00001) || (opc == decode_pkg::opc_special && fn[5:1] == 5'b00100);
    call = (opc == decode_pkg::opc_jal) || (opc == decode_pkg::opc_regimm && rt[4:1] == 4'b1000)
        || (opc == decode_pkg::opc_special && fn == decode_pkg::fn_jalr);
    ret  = (opc == decode_pkg::opc_special) && (fn == decode_pkg::fn_jr)
        && (rs == decode_pkg::link_reg);
    r.cf_info.is_controlflow = br | jmp;
    r.cf_info.cf = br   ? decode_pkg::ControlFlow_Branch :
                   ret  ? decode_pkg::ControlFlow_Return :
                   call ? decode_pkg::ControlFlow_Call :
                   jmp  ? decode_pkg::ControlFlow_Jump : decode_pkg::ControlFlow_None;
    r.cf_info.default_jump_i = pc4 + {{14{inst[15]}}, inst[15:0], 2'b00};
    r.cf_info.default_jump_j = {pc4[31:28], inst[25:0], 2'b00};
    return r;
endfunction

`endif

/* sim/decoder_tb.sv */
// decoder testbench
`timescale 1ns/1ps
`default_nettype none

module decoder_tb;

    `include "decode_ref.svh"

    localparam time clk_period = 4;

    // directed words, kept and dropped encodings
    localparam logic [31:0] directed_insts [0:34] = '{
        32'h0022_1820, 32'h0085_0018, 32'h0085_001b, 32'h00c0_0011, 32'h0000_3812,
        32'h03e0_0008, 32'h0120_0008, 32'h0120_f809, 32'h0000_000c, 32'h0022_180a,
        32'h2422_fffc, 32'h2822_8000, 32'h3422_1234, 32'h3c02_8000, 32'h8025_0004,
        32'h8425_0002, 32'h8c25_0010, 32'h9025_0004, 32'h9425_0006, 32'h9c25_0000,
        32'ha025_0001, 32'ha425_0002, 32'hac25_fff0, 32'hb825_0000, 32'h1022_fffe,
        32'h1c20_0010, 32'h0420_0004, 32'h0430_0008, 32'h0431_0008, 32'h0428_0000,
        32'h0800_0100, 32'h0c10_0000, 32'h4002_6000, 32'h4082_6000, 32'h4200_0018
    };

    localparam logic [5:0] opcode_table [0:31] = '{
        6'o00, 6'o00, 6'o00, 6'o01, 6'o01, 6'o02, 6'o03, 6'o04,
        6'o05, 6'o06, 6'o07, 6'o10, 6'o11, 6'o12, 6'o14, 6'o16,
        6'o17, 6'o40, 6'o41, 6'o42, 6'o43, 6'o44, 6'o45, 6'o47,
        6'o50, 6'o51, 6'o53, 6'o56, 6'o20, 6'o21, 6'o34, 6'o60    // last five dropped or cop
    };

    logic                          clk;
    logic                          reset;
    logic                          in_valid;
    decode_pkg::virt_t             in_vaddr;
    logic [decode_pkg::word_w-1:0] in_inst;
    logic                          resp_valid;
    decode_pkg::decoder_resp_t     resp;

    logic [31:0]               lfsr_state = 32'h7432_c851;
    decode_pkg::decoder_resp_t exp_q [$];
    time                       due_q [$];
    int                        errors  = 0;
    int                        sent    = 0;
    int                        checked = 0;

    decoder_top decoder_top_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_vaddr   (in_vaddr),
        .in_inst    (in_inst),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    always #(clk_period / 2) clk = ~clk;

    // galois lfsr, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003)
                                       : (lfsr_state >> 1);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] random_inst();
        logic [4:0]  idx;
        logic [31:0] low;
        logic [31:0] inst;
        idx  = 5'(take_bits(5));
        low  = take_bits(26);
        inst = {opcode_table[idx], low[25:0]};
        if (inst[31:26] == decode_pkg::opc_special && take_bits(3) == 0) begin
            inst[25:21] = decode_pkg::link_reg;    // a return now and then
            inst[5:0]   = decode_pkg::fn_jr;
        end
        if (inst[31:26] == decode_pkg::opc_cop0) begin
            case (2'(take_bits(2)))
                2'd0: inst[25:21] = decode_pkg::cop0_mf;
                2'd1: inst[25:21] = decode_pkg::cop0_mt;
                2'd2: begin
                    inst[25:21] = decode_pkg::cop0_co;
                    inst[5:0]   = decode_pkg::fn_eret;
                end
                default: ;
            endcase
        end
        return inst;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("FAIL %0t %s got %0h expected %0h", $time, name, got, want);
        end
    endtask

    task automatic compare_resp(input decode_pkg::decoder_resp_t got,
                                input decode_pkg::decoder_resp_t want);
        check_field("rs1", 32'(got.dec.rs1), 32'(want.dec.rs1));
        check_field("rs2", 32'(got.dec.rs2), 32'(want.dec.rs2));
        check_field("rd", 32'(got.dec.rd), 32'(want.dec.rd));
        check_field("op", 32'(got.dec.op), 32'(want.dec.op));
        check_field("use_imm", 32'(got.dec.use_imm), 32'(want.dec.use_imm));
        check_field("imm_signed", 32'(got.dec.imm_signed), 32'(want.dec.imm_signed));
        check_field("is_load", 32'(got.dec.is_load), 32'(want.dec.is_load));
        check_field("is_store", 32'(got.dec.is_store), 32'(want.dec.is_store));
        check_field("is_multicyc", 32'(got.dec.is_multicyc), 32'(want.dec.is_multicyc));
        check_field("be", 32'(got.dec.be), 32'(want.dec.be));
        check_field("cf", 32'(got.cf_info.cf), 32'(want.cf_info.cf));
        check_field("is_controlflow", 32'(got.cf_info.is_controlflow),
                    32'(want.cf_info.is_controlflow));
        check_field("default_jump_i", got.cf_info.default_jump_i,
                    want.cf_info.default_jump_i);
        check_field("default_jump_j", got.cf_info.default_jump_j,
                    want.cf_info.default_jump_j);
    endtask

    task automatic drive_inst(input decode_pkg::virt_t vaddr, input logic [31:0] inst);
        @(posedge clk);
        in_valid <= 1'b1;
        in_vaddr <= vaddr;
        in_inst  <= inst;
        exp_q.push_back(decode_ref(vaddr, inst));
        due_q.push_back($time + 2 * clk_period);    // registered two edges after the drive edge
        sent++;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            if (resp_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("%0t: response arrived with no instruction outstanding", $time);
                end else begin
                    check_field("resp_time", 32'($time - clk_period / 2), 32'(due_q[0]));
                    compare_resp(resp, exp_q[0]);
                    void'(exp_q.pop_front());
                    void'(due_q.pop_front());
                    checked++;
                end
            end else if (due_q.size() > 0 && $time > due_q[0]) begin
                errors++;
                $display("%0t: expected response did not arrive", $time);
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end
        end
    end

    initial begin
        int wait_cnt;
        clk      = 1'b0;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_vaddr = '0;
        in_inst  = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        repeat (4) begin
            @(negedge clk);
            check_field("resp_valid", 32'(resp_valid), 32'd0);
            compare_resp(resp, '0);
        end

        for (int i = 0; i < 35; i++) begin
            drive_inst({30'(take_bits(30)), 2'b00}, directed_insts[i]);
        end
        drive_idle();

        for (int i = 0; i < 400; i++) begin
            if (take_bits(2) != 0) begin
                drive_inst({30'(take_bits(30)), 2'b00}, random_inst());
            end else begin
                drive_idle();
            end
        end
        drive_idle();

        wait_cnt = 0;
        while (exp_q.size() != 0 && wait_cnt < 20) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("timeout with %0d responses still outstanding", exp_q.size());
        end
        repeat (4) @(posedge clk);
        if (checked != sent) begin
            errors++;
            $display("sent %0d instructions but checked %0d responses", sent, checked);
        end

        $display("errors: %0d, responses checked: %0d", errors, checked);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/decoder_top.sv */
// mips32 registered decoder
`timescale 1ns/1ps
`default_nettype none

module decoder_top (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic                          in_valid,
    input  wire decode_pkg::virt_t             in_vaddr,
    input  wire logic [decode_pkg::word_w-1:0] in_inst,
    output logic                               resp_valid,
    output decode_pkg::decoder_resp_t          resp
);

    logic                     fields_valid;
    decode_pkg::inst_fields_t fields;
    decode_pkg::decode_t      dec;
    decode_pkg::cf_info_t     cf_info;

    inst_capture inst_capture_i (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_vaddr     (in_vaddr),
        .in_inst      (in_inst),
        .fields_valid (fields_valid),
        .fields       (fields)
    );

    opcode_decode opcode_decode_i (
        .fields (fields),
        .dec    (dec)
    );

    control_flow_unit control_flow_unit_i (
        .fields  (fields),
        .cf_info (cf_info)
    );

    resp_stage resp_stage_i (
        .clk          (clk),
        .reset        (reset),
        .fields_valid (fields_valid),
        .dec          (dec),
        .cf_info      (cf_info),
        .resp_valid   (resp_valid),
        .resp         (resp)
    );

endmodule

`default_nettype wire

/* design/resp_stage.sv */
// registered decoder response
`timescale 1ns/1ps
`default_nettype none

module resp_stage (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  fields_valid,
    input  wire decode_pkg::decode_t   dec,
    input  wire decode_pkg::cf_info_t  cf_info,
    output logic                       resp_valid,
    output decode_pkg::decoder_resp_t  resp
);

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
            resp       <= '0;
        end else begin
            resp_valid <= fields_valid;
            if (fields_valid) begin
                resp.dec     <= dec;
                resp.cf_info <= cf_info;
            end
        end
    end

    a_ld_st_excl: assert property (@(posedge clk) disable iff (reset)
        resp_valid |-> !(resp.dec.is_load && resp.dec.is_store))
        else $error("resp_stage: load and store both set");

    // a control-flow response always carries a class
    a_cf_class: assert property (@(posedge clk) disable iff (reset)
        (resp_valid && resp.cf_info.is_controlflow)
            |-> resp.cf_info.cf != decode_pkg::ControlFlow_None)
        else $error("resp_stage: control flow without a class");

endmodule

`default_nettype wire

/* design/control_flow_unit.sv */
// control-flow classifier
`timescale 1ns/1ps
`default_nettype none

module control_flow_unit (
    input  wire decode_pkg::inst_fields_t fields,
    output decode_pkg::cf_info_t          cf_info
);

    logic              is_special;
    logic              is_regimm;
    logic              is_branch;
    logic              is_jump_i;
    logic              is_jump_r;
    logic              is_call;
    logic              is_return;
    decode_pkg::virt_t pc_plus4;

    assign is_special = (fields.opcode == decode_pkg::opc_special);
    assign is_regimm  = (fields.opcode == decode_pkg::opc_regimm);

    // rt x000x are the four regimm branches
    assign is_branch = (fields.opcode[5:2] == 4'b0001)
                    || (is_regimm && fields.rt[3:1] == 3'b000);
    assign is_jump_i = (fields.opcode[5:1] == 5'b00001);
    assign is_jump_r = is_special && (fields.funct[5:1] == 5'b00100);
    assign is_call   = (fields.opcode == decode_pkg::opc_jal)
                    || (is_special && fields.funct == decode_pkg::fn_jalr)
                    || (is_regimm && fields.rt[4:1] == 4'b1000);
    assign is_return = is_special && (fields.funct == decode_pkg::fn_jr)
                    && (fields.rs == decode_pkg::link_reg);

    always_comb begin
        casez ({is_branch, is_return, is_call, is_jump_i | is_jump_r})
            4'b1???: cf_info.cf = decode_pkg::ControlFlow_Branch;
            4'b01??: cf_info.cf = decode_pkg::ControlFlow_Return;
            4'b001?: cf_info.cf = decode_pkg::ControlFlow_Call;
            4'b0001: cf_info.cf = decode_pkg::ControlFlow_Jump;
            default: cf_info.cf = decode_pkg::ControlFlow_None;
        endcase
    end

    assign cf_info.is_controlflow = is_branch | is_jump_i | is_jump_r;

    assign pc_plus4 = fields.vaddr + 32'd4;
    assign cf_info.default_jump_i = pc_plus4
                                  + {{14{fields.imm16[15]}}, fields.imm16, 2'b00};
    assign cf_info.default_jump_j = {pc_plus4[31:28], fields.target26, 2'b00};

endmodule

`default_nettype wire

/* design/opcode_decode.sv */
// main opcode decoder
`timescale 1ns/1ps
`default_nettype none

module opcode_decode (
    input  wire decode_pkg::inst_fields_t fields,
    output decode_pkg::decode_t           dec
);

    logic [decode_pkg::be_w-1:0] size_be;
    logic                        special_multicyc;

    // access size from low opcode bits
    always_comb begin
        case (fields.opcode[1:0])
            2'b00:   size_be = decode_pkg::be_byte;
            2'b01:   size_be = decode_pkg::be_half;
            2'b11:   size_be = decode_pkg::be_word;
            default: size_be = '0;
        endcase
    end

    assign special_multicyc = (fields.funct[5:2] == 4'b0110)    // mult/div
                            || (fields.funct == decode_pkg::fn_mthi)
                            || (fields.funct == decode_pkg::fn_mtlo);

    always_comb begin
        dec            = '0;
        dec.op         = decode_pkg::OP_SLL;
        dec.imm_signed = 1'b1;

        casez (fields.opcode)
            decode_pkg::opc_special: begin
                dec.rs1         = fields.rs;
                dec.rs2         = fields.rt;
                dec.rd          = fields.rd;
                dec.is_multicyc = special_multicyc;
                case (fields.funct)
                    6'b000000:              dec.op = decode_pkg::OP_SLL;
                    6'b000010:              dec.op = decode_pkg::OP_SRL;
                    6'b000011:              dec.op = decode_pkg::OP_SRA;
                    6'b000100:              dec.op = decode_pkg::OP_SLLV;
                    6'b000110:              dec.op = decode_pkg::OP_SRLV;
                    6'b000111:              dec.op = decode_pkg::OP_SRAV;
                    decode_pkg::fn_jr,
                    decode_pkg::fn_jalr:    dec.op = decode_pkg::OP_JALR;
                    decode_pkg::fn_syscall: dec.op = decode_pkg::OP_SYSCALL;
                    decode_pkg::fn_break:   dec.op = decode_pkg::OP_BREAK;
                    6'b010000:              dec.op = decode_pkg::OP_MFHI;
                    decode_pkg::fn_mthi:    dec.op = decode_pkg::OP_MTHI;
                    6'b010010:              dec.op = decode_pkg::OP_MFLO;
                    decode_pkg::fn_mtlo:    dec.op = decode_pkg::OP_MTLO;
                    6'b011000:              dec.op = decode_pkg::OP_MULT;
                    6'b011001:              dec.op = decode_pkg::OP_MULTU;
                    6'b011010:              dec.op = decode_pkg::OP_DIV;
                    6'b011011:              dec.op = decode_pkg::OP_DIVU;
                    6'b100000:              dec.op = decode_pkg::OP_ADD;
                    6'b100001:              dec.op = decode_pkg::OP_ADDU;
                    6'b100010:              dec.op = decode_pkg::OP_SUB;
                    6'b100011:              dec.op = decode_pkg::OP_SUBU;
                    6'b100100:              dec.op = decode_pkg::OP_AND;
                    6'b100101:              dec.op = decode_pkg::OP_OR;
                    6'b100110:              dec.op = decode_pkg::OP_XOR;
                    6'b100111:              dec.op = decode_pkg::OP_NOR;
                    6'b101010:              dec.op = decode_pkg::OP_SLT;
                    6'b101011:              dec.op = decode_pkg::OP_SLTU;
                    default:                dec.op = decode_pkg::OP_INVALID;
                endcase
            end

            decode_pkg::opc_regimm: begin
                dec.rs1     = fields.rs;
                dec.use_imm = 1'b1;
                dec.rd      = (fields.rt[4:1] == 4'b1000) ? decode_pkg::link_reg : '0;
                case (fields.rt)
                    5'b00000: dec.op = decode_pkg::OP_BLTZ;
                    5'b00001: dec.op = decode_pkg::OP_BGEZ;
                    5'b10000: dec.op = decode_pkg::OP_BLTZAL;
                    5'b10001: dec.op = decode_pkg::OP_BGEZAL;
                    default:  dec.op = decode_pkg::OP_INVALID;
                endcase
            end

            6'b0001??: begin    // beq/bne/blez/bgtz
                dec.rs1 = fields.rs;
                dec.rs2 = fields.rt;
                case (fields.opcode[1:0])
                    2'b00:   dec.op = decode_pkg::OP_BEQ;
                    2'b01:   dec.op = decode_pkg::OP_BNE;
                    2'b10:   dec.op = decode_pkg::OP_BLEZ;
                    default: dec.op = decode_pkg::OP_BGTZ;
                endcase
            end

            6'b001???: begin    // reg-imm alu
                dec.rs1        = fields.rs;
                dec.rd         = fields.rt;
                dec.use_imm    = 1'b1;
                dec.imm_signed = ~fields.opcode[2];
                case (fields.opcode[2:0])
                    3'b000:  dec.op = decode_pkg::OP_ADD;
                    3'b001:  dec.op = decode_pkg::OP_ADDU;
                    3'b010:  dec.op = decode_pkg::OP_SLT;
                    3'b011:  dec.op = decode_pkg::OP_SLTU;
                    3'b100:  dec.op = decode_pkg::OP_AND;
                    3'b101:  dec.op = decode_pkg::OP_OR;
                    3'b110:  dec.op = decode_pkg::OP_XOR;
                    default: dec.op = decode_pkg::OP_LUI;
                endcase
            end

            6'b100???: begin
                dec.rs1     = fields.rs;
                dec.rs2     = (fields.opcode[1:0] == 2'b10) ? fields.rt : '0;
                dec.rd      = fields.rt;
                dec.is_load = 1'b1;
                case (fields.opcode[2:0])
                    3'b000:  dec.op = decode_pkg::OP_LB;
                    3'b001:  dec.op = decode_pkg::OP_LH;
                    3'b011:  dec.op = decode_pkg::OP_LW;
                    3'b100:  dec.op = decode_pkg::OP_LBU;
                    3'b101:  dec.op = decode_pkg::OP_LHU;
                    default: dec.op = decode_pkg::OP_INVALID;
                endcase
                if (dec.op != decode_pkg::OP_INVALID) begin
                    dec.be = size_be;
                end
            end

            6'b101???: begin
                dec.rs1      = fields.rs;
                dec.rs2      = fields.rt;
                dec.is_store = 1'b1;
                case (fields.opcode[2:0])
                    3'b000:  dec.op = decode_pkg::OP_SB;
                    3'b001:  dec.op = decode_pkg::OP_SH;
                    3'b011:  dec.op = decode_pkg::OP_SW;
                    default: dec.op = decode_pkg::OP_INVALID;
                endcase
                if (dec.op != decode_pkg::OP_INVALID) begin
                    dec.be = size_be;
                end
            end

            decode_pkg::opc_j, decode_pkg::opc_jal: begin
                dec.op = decode_pkg::OP_JAL;
                dec.rd = fields.opcode[0] ? decode_pkg::link_reg : '0;
            end

            decode_pkg::opc_cop0: begin
                case (fields.rs)
                    decode_pkg::cop0_mf: begin
                        dec.op = decode_pkg::OP_MFC0;
                        dec.rd = fields.rt;
                    end
                    decode_pkg::cop0_mt: begin
                        dec.op  = decode_pkg::OP_MTC0;
                        dec.rs1 = fields.rt;
                    end
                    decode_pkg::cop0_co: begin
                        dec.op = (fields.funct == decode_pkg::fn_eret) ?
                                 decode_pkg::OP_ERET : decode_pkg::OP_INVALID;
                    end
                    default: dec.op = decode_pkg::OP_INVALID;
                endcase
            end

            default: dec.op = decode_pkg::OP_INVALID;
        endcase
    end

endmodule

`default_nettype wire

/* design/inst_capture.sv */
// instruction capture stage
`timescale 1ns/1ps
`default_nettype none

module inst_capture (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire logic                         in_valid,
    input  wire decode_pkg::virt_t            in_vaddr,
    input  wire logic [decode_pkg::word_w-1:0] in_inst,
    output logic                              fields_valid,
    output decode_pkg::inst_fields_t          fields
);

    decode_pkg::virt_t               vaddr_q;
    logic [decode_pkg::word_w-1:0]   inst_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            fields_valid <= 1'b0;
        end else begin
            fields_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            vaddr_q <= in_vaddr;
            inst_q  <= in_inst;
        end
    end

    always_comb begin
        fields.vaddr    = vaddr_q;
        fields.opcode   = inst_q[31:26];
        fields.rs       = inst_q[25:21];
        fields.rt       = inst_q[20:16];
        fields.rd       = inst_q[15:11];
        fields.funct    = inst_q[5:0];
        fields.imm16    = inst_q[15:0];
        fields.target26 = inst_q[25:0];
    end

    // a strobed word must be fully known, it is decoded next cycle
    a_inst_known: assert property (@(posedge clk) disable iff (reset)
        in_valid |-> !$isunknown(in_inst))
        else $error("inst_capture: unknown bits in strobed instruction");

endmodule

`default_nettype wire

/* design/decode_pkg.sv */
// mips32 decoder definitions
`default_nettype none

package decode_pkg;

    localparam int word_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int be_w       = 4;

    typedef logic [word_w-1:0]     virt_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    localparam reg_addr_t link_reg = 5'd31;

    // major opcodes
    localparam logic [5:0] opc_special = 6'b000000;
    localparam logic [5:0] opc_regimm  = 6'b000001;
    localparam logic [5:0] opc_j       = 6'b000010;
    localparam logic [5:0] opc_jal     = 6'b000011;
    localparam logic [5:0] opc_cop0    = 6'b010000;

    // funct codes with a role beyond the op table
    localparam logic [5:0] fn_jr      = 6'b001000;
    localparam logic [5:0] fn_jalr    = 6'b001001;
    localparam logic [5:0] fn_syscall = 6'b001100;
    localparam logic [5:0] fn_break   = 6'b001101;
    localparam logic [5:0] fn_mthi    = 6'b010001;
    localparam logic [5:0] fn_mtlo    = 6'b010011;
    localparam logic [5:0] fn_eret    = 6'b011000;   // under cop0 co

    // cop0 rs sub-codes
    localparam reg_addr_t cop0_mf = 5'b00000;
    localparam reg_addr_t cop0_mt = 5'b00100;
    localparam reg_addr_t cop0_co = 5'b10000;

    localparam logic [be_w-1:0] be_byte = 4'b0001;
    localparam logic [be_w-1:0] be_half = 4'b0011;
    localparam logic [be_w-1:0] be_word = 4'b1111;

    typedef enum logic [5:0] {
        OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
        OP_JALR, OP_SYSCALL, OP_BREAK,
        OP_MFHI, OP_MTHI, OP_MFLO, OP_MTLO,
        OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
        OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLT, OP_SLTU, OP_LUI,
        OP_BLTZ, OP_BGEZ, OP_BLTZAL, OP_BGEZAL,
        OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_JAL, OP_MFC0, OP_MTC0, OP_ERET,
        OP_INVALID
    } op_t;

    typedef enum logic [2:0] {
        ControlFlow_None,
        ControlFlow_Branch,
        ControlFlow_Return,
        ControlFlow_Call,
        ControlFlow_Jump
    } cf_t;

    typedef struct packed {
        virt_t       vaddr;
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [5:0]  funct;
        logic [15:0] imm16;
        logic [25:0] target26;
    } inst_fields_t;

    typedef struct packed {
        reg_addr_t       rs1;
        reg_addr_t       rs2;
        reg_addr_t       rd;
        op_t             op;
        logic            use_imm;
        logic            imm_signed;
        logic            is_load;
        logic            is_store;
        logic            is_multicyc;
        logic [be_w-1:0] be;
    } decode_t;

    typedef struct packed {
        cf_t   cf;
        logic  is_controlflow;
        virt_t default_jump_i;
        virt_t default_jump_j;
    } cf_info_t;

    typedef struct packed {
        decode_t  dec;
        cf_info_t cf_info;
    } decoder_resp_t;

endpackage

`default_nettype wire
